//--- Bender.yml
package:
  name: fifo_window

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fifo_win_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/avail_notifier.sv
      - rtl/apb_fifo_port.sv
      - rtl/fifo_window_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/fifo_window_tb.sv

//--- rtl/apb_fifo_port.sv
// APB subordinate for the FIFO window; data accesses stall with wait states, unmapped offsets error
`timescale 1ns/100ps
`include "fifo_win_defines.svh"

module apb_fifo_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fifo_win_pkg::apb_req_t     req_i,
    output fifo_win_pkg::apb_rsp_t     rsp_o,
    output logic                       wr_valid_o,
    output logic [`FW_DATA_W-1:0]      wr_data_o,
    input  logic                       wr_ready_i,
    output logic                       rd_ready_o,
    input  logic                       rd_valid_i,
    input  logic [`FW_DATA_W-1:0]      rd_data_i,
    output logic                       clear_o,
    input  fifo_win_pkg::fifo_stat_t   stat_i,
    input  logic                       avail_i,
    output fifo_win_pkg::avail_cfg_t   cfg_o
);

    import fifo_win_pkg::*;

    // Self-clearing CTRL bit that flushes the FIFO
    localparam int CLR_BIT = 8;
    localparam int CFG_W   = $bits(avail_cfg_t);
    localparam int STAT_W  = $bits(fifo_stat_t);

    logic                  access;
    logic                  is_data;
    logic                  is_ctrl;
    logic                  is_stat;
    logic                  ctrl_wr;
    logic [`FW_DATA_W-1:0] prdata;
    avail_cfg_t            ctrl_q;
    logic                  clear_q;

    // Access phase of any transfer
    assign access  = req_i.psel && req_i.penable;

    assign is_data = (req_i.paddr == `FW_ADDR_DATA);
    assign is_ctrl = (req_i.paddr == `FW_ADDR_CTRL);
    assign is_stat = (req_i.paddr == `FW_ADDR_STAT);

    assign ctrl_wr = access && req_i.pwrite && is_ctrl;

    // FIFO handshakes are offered for every access cycle on the data offset
    assign wr_valid_o = access && req_i.pwrite && is_data;
    assign rd_ready_o = access && !req_i.pwrite && is_data;
    assign wr_data_o  = req_i.pwdata;

    // Register accesses finish at once; data waits on the FIFO
    always_comb begin
        rsp_o.pready  = 1'b0;
        rsp_o.pslverr = 1'b0;
        if (access) begin
            if (is_data) begin
                rsp_o.pready = req_i.pwrite ? wr_ready_i : rd_valid_i;
            end else begin
                rsp_o.pready  = 1'b1;
                rsp_o.pslverr = !(is_ctrl || is_stat);
            end
        end
    end

    // Read data mux
    always_comb begin
        prdata = '0;
        if (is_data) begin
            prdata = rd_data_i;
        end else if (is_ctrl) begin
            prdata[CFG_W-1:0] = ctrl_q;
        end else if (is_stat) begin
            prdata[STAT_W-1:0] = stat_i;
            prdata[STAT_W]     = avail_i;
        end
    end

    assign rsp_o.prdata = prdata;

    // Control register and flush pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q  <= '0;
            clear_q <= 1'b0;
        end else begin
            clear_q <= ctrl_wr && req_i.pwdata[CLR_BIT];
            if (ctrl_wr) begin
                ctrl_q <= avail_cfg_t'(req_i.pwdata[CFG_W-1:0]);
            end
        end
    end

    assign clear_o = clear_q;
    assign cfg_o   = ctrl_q;

endmodule

//--- rtl/avail_notifier.sv
// Registered data-available flag; burst counters restart whenever burst mode is not selected
`timescale 1ns/100ps
`include "fifo_win_defines.svh"

module avail_notifier (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fifo_win_pkg::avail_cfg_t cfg_i,
    input  fifo_win_pkg::fifo_stat_t stat_i,
    input  logic                     wr_fire_i,
    input  logic                     rd_fire_i,
    output logic                     avail_o
);

    import fifo_win_pkg::*;

    // Counters are a few bits wider than the occupancy
    localparam int CW = `FW_CNT_W + 3;
    localparam logic [CW-1:0] BURST = CW'(`FW_BURST_WORDS);

    logic          active;
    logic          burst_on;
    logic [CW-1:0] pending_q;
    logic [CW-1:0] announced_q;
    logic [CW-1:0] popped_q;
    logic [CW-1:0] pend_sum;
    logic [CW-1:0] pop_sum;
    logic          last_pop;
    logic          set_evt;
    logic          burst_q;
    logic          burst_next;
    logic          avail_q;

    assign active   = cfg_i.enable && (cfg_i.mode != MODE_OFF);
    assign burst_on = active && (cfg_i.mode == MODE_BURST);

    // Counts including this cycle's handshakes
    assign pend_sum = pending_q + CW'(wr_fire_i);
    assign pop_sum  = popped_q + CW'(rd_fire_i);

    // Final pop of everything announced so far
    assign last_pop = rd_fire_i && burst_q && (pop_sum == announced_q);

    // A full burst announces when idle or when the previous one drains
    assign set_evt = (pend_sum >= BURST) && (!burst_q || last_pop);

    always_comb begin
        burst_next = burst_q;
        if (set_evt) begin
            burst_next = 1'b1;
        end else if (last_pop) begin
            burst_next = 1'b0;
        end
    end

    // Burst bookkeeping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q   <= '0;
            announced_q <= '0;
            popped_q    <= '0;
            burst_q     <= 1'b0;
        end else if (!burst_on) begin
            pending_q   <= '0;
            announced_q <= '0;
            popped_q    <= '0;
            burst_q     <= 1'b0;
        end else begin
            popped_q <= pop_sum;
            burst_q  <= burst_next;
            if (set_evt) begin
                pending_q   <= pend_sum - BURST;
                announced_q <= announced_q + BURST;
            end else begin
                pending_q <= pend_sum;
            end
        end
    end

    // Output flag per mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            avail_q <= 1'b0;
        end else if (!active) begin
            avail_q <= 1'b0;
        end else begin
            case (cfg_i.mode)
                MODE_NOT_EMPTY: avail_q <= (stat_i.depth != '0);
                MODE_THRESH:    avail_q <= (stat_i.depth >= cfg_i.thresh);
                MODE_BURST:     avail_q <= burst_next;
                default:        avail_q <= 1'b0;
            endcase
        end
    end

    assign avail_o = avail_q;

endmodule

//--- rtl/fifo_win_defines.svh
// Sizes and APB offsets for the FIFO window; FW_BURST_WORDS must be a power of two <= FW_DEPTH
`ifndef FIFO_WIN_DEFINES_SVH
`define FIFO_WIN_DEFINES_SVH

// Data path and APB word width
`define FW_DATA_W      32

// FIFO depth in words
`define FW_DEPTH       16
// Pointer and occupancy widths derived from the depth
`define FW_PTR_W       ($clog2(`FW_DEPTH))
`define FW_CNT_W       ($clog2(`FW_DEPTH + 1))

// Words announced per burst in burst mode
`define FW_BURST_WORDS 4

// APB byte offsets within a 4-bit address space
`define FW_ADDR_W      4
`define FW_ADDR_DATA   4'h0
`define FW_ADDR_CTRL   4'h4
`define FW_ADDR_STAT   4'h8

`endif

//--- rtl/fifo_win_pkg.sv
// Bus, control and status types for the FIFO window; widths follow fifo_win_defines.svh
`include "fifo_win_defines.svh"

package fifo_win_pkg;

    // APB request as seen by the subordinate
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [`FW_ADDR_W-1:0] paddr;
        logic [`FW_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`FW_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // Notification modes held in CTRL[6:5]
    typedef enum logic [1:0] {
        MODE_OFF,
        MODE_NOT_EMPTY,
        MODE_THRESH,
        MODE_BURST
    } avail_mode_e;

    // Stored in CTRL[7:0]
    typedef struct packed {
        logic        enable;
        avail_mode_e mode;
        logic [4:0]  thresh;
    } avail_cfg_t;

    typedef struct packed {
        logic                 full;
        logic                 empty;
        logic [`FW_CNT_W-1:0] depth;
    } fifo_stat_t;

endpackage

//--- rtl/fifo_window_top.sv
// APB FIFO window top; a full FIFO stalls writes and an empty one stalls reads, nothing is dropped
`timescale 1ns/100ps
`include "fifo_win_defines.svh"

module fifo_window_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  fifo_win_pkg::apb_req_t apb_req_i,
    output fifo_win_pkg::apb_rsp_t apb_rsp_o,
    output logic                   avail_o
);

    import fifo_win_pkg::*;

    logic                  wr_valid;
    logic                  wr_ready;
    logic [`FW_DATA_W-1:0] wr_data;
    logic                  rd_valid;
    logic                  rd_ready;
    logic [`FW_DATA_W-1:0] rd_data;
    logic                  clear;
    logic                  wr_fire;
    logic                  rd_fire;
    fifo_stat_t            stat;
    avail_cfg_t            cfg;

    // Push and pop strobes for the notifier
    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    apb_fifo_port u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (apb_req_i),
        .rsp_o      (apb_rsp_o),
        .wr_valid_o (wr_valid),
        .wr_data_o  (wr_data),
        .wr_ready_i (wr_ready),
        .rd_ready_o (rd_ready),
        .rd_valid_i (rd_valid),
        .rd_data_i  (rd_data),
        .clear_o    (clear),
        .stat_i     (stat),
        .avail_i    (avail_o),
        .cfg_o      (cfg)
    );

    sync_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_i    (clear),
        .wr_valid_i (wr_valid),
        .wr_data_i  (wr_data),
        .wr_ready_o (wr_ready),
        .rd_valid_o (rd_valid),
        .rd_ready_i (rd_ready),
        .rd_data_o  (rd_data),
        .stat_o     (stat)
    );

    avail_notifier u_notifier (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_i     (cfg),
        .stat_i    (stat),
        .wr_fire_i (wr_fire),
        .rd_fire_i (rd_fire),
        .avail_o   (avail_o)
    );

endmodule

//--- rtl/sync_fifo.sv
// Single-clock FIFO without pass-through; read data is zero while empty and clear beats a push
`timescale 1ns/100ps
`include "fifo_win_defines.svh"

module sync_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     clear_i,
    input  logic                     wr_valid_i,
    input  logic [`FW_DATA_W-1:0]    wr_data_i,
    output logic                     wr_ready_o,
    output logic                     rd_valid_o,
    input  logic                     rd_ready_i,
    output logic [`FW_DATA_W-1:0]    rd_data_o,
    output fifo_win_pkg::fifo_stat_t stat_o
);

    localparam int PTR_W = `FW_PTR_W;
    localparam logic [PTR_W-1:0]     LAST_PTR = PTR_W'(`FW_DEPTH - 1);
    localparam logic [`FW_CNT_W-1:0] FULL_CNT = `FW_DEPTH;

    logic [`FW_DATA_W-1:0] mem_q [`FW_DEPTH];
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [`FW_CNT_W-1:0]  count_q;
    logic                  push;
    logic                  pop;

    assign wr_ready_o = (count_q != FULL_CNT);
    assign rd_valid_o = (count_q != '0);

    assign push = wr_valid_i && wr_ready_o && !clear_i;
    assign pop  = rd_valid_o && rd_ready_i && !clear_i;

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    assign rd_data_o = rd_valid_o ? mem_q[rd_ptr_q] : '0;

    assign stat_o.full  = !wr_ready_o;
    assign stat_o.empty = !rd_valid_o;
    assign stat_o.depth = count_q;

endmodule

//--- sim.f
+incdir+rtl
rtl/fifo_win_pkg.sv
rtl/sync_fifo.sv
rtl/avail_notifier.sv
rtl/apb_fifo_port.sv
rtl/fifo_window_top.sv
tests/fifo_window_tb.sv

//--- tests/fifo_window_tb.sv
// Testbench for fifo_window_top; one APB master only, so stalled data accesses are withdrawn
`timescale 1ns/100ps
`include "fifo_win_defines.svh"

module fifo_window_tb;

    import fifo_win_pkg::*;

    localparam int TIMEOUT = 64;
    localparam int BURST   = `FW_BURST_WORDS;

    logic                  clk;
    logic                  rst_n;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    logic                  avail;
    avail_cfg_t            cfg;
    logic [`FW_DATA_W-1:0] model_q[$];
    logic [`FW_DATA_W-1:0] rdata;
    logic                  slverr;
    logic                  burst;
    logic                  exp_avail;
    logic                  chk_en;
    int                    pending;
    int                    announced;
    int                    popped;
    int                    errors;
    int                    test_start;
    int                    ntests;

    fifo_window_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp),
        .avail_o   (avail)
    );

    always #10 clk = ~clk;

    // Expected flag from the notifier rules
    function automatic logic ref_avail(avail_cfg_t c, int depth, logic burst_flag);
        logic result;
        result = 1'b0;
        if (c.enable) begin
            case (c.mode)
                MODE_NOT_EMPTY: result = (depth != 0);
                MODE_THRESH:    result = (depth >= c.thresh);
                MODE_BURST:     result = burst_flag;
                default:        result = 1'b0;
            endcase
        end
        return result;
    endfunction

    // Flag is stable between settle and the next completing transfer
    always @(negedge clk) begin
        if (chk_en && avail !== exp_avail) begin
            $display("ERROR avail_o: got %h expected %h at %0t", avail, exp_avail, $time);
            errors++;
        end
    end

    task automatic apb_xfer(input logic wr, input logic [`FW_ADDR_W-1:0] addr,
                            input logic [`FW_DATA_W-1:0] wdata);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        while (!apb_rsp.pready && waits < TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: offset %h gave no pready within %0d cycles", addr, TIMEOUT);
            errors++;
        end
        chk_en = 1'b0;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    // Registered flag settles two edges after the transfer
    task automatic settle();
        exp_avail = ref_avail(cfg, model_q.size(), burst);
        repeat (2) @(posedge clk);
        chk_en = 1'b1;
    endtask

    task automatic push_word(input logic [`FW_DATA_W-1:0] data);
        apb_xfer(1'b1, `FW_ADDR_DATA, data);
        model_q.push_back(data);
        if (cfg.enable && cfg.mode == MODE_BURST) begin
            pending++;
            if (!burst && pending >= BURST) begin
                burst     = 1'b1;
                pending   = pending - BURST;
                announced = announced + BURST;
            end
        end
        settle();
    endtask

    task automatic pop_word();
        logic [`FW_DATA_W-1:0] expected;
        expected = model_q.pop_front();
        apb_xfer(1'b0, `FW_ADDR_DATA, '0);
        if (rdata !== expected) begin
            $display("ERROR prdata: got %h expected %h", rdata, expected);
            errors++;
        end
        if (cfg.enable && cfg.mode == MODE_BURST) begin
            popped++;
            // Last announced word read; a waiting full burst re-arms at once
            if (burst && popped == announced) begin
                if (pending >= BURST) begin
                    pending   = pending - BURST;
                    announced = announced + BURST;
                end else begin
                    burst = 1'b0;
                end
            end
        end
        settle();
    endtask

    task automatic write_ctrl(input avail_cfg_t c, input logic flush);
        logic [`FW_DATA_W-1:0] want;
        want = {{(`FW_DATA_W-8){1'b0}}, c};
        apb_xfer(1'b1, `FW_ADDR_CTRL, {{(`FW_DATA_W-9){1'b0}}, flush, c});
        // Flush bit is not stored
        apb_xfer(1'b0, `FW_ADDR_CTRL, '0);
        if (rdata !== want) begin
            $display("ERROR prdata (CTRL): got %h expected %h", rdata, want);
            errors++;
        end
        cfg = c;
        if (!(c.enable && c.mode == MODE_BURST)) begin
            pending   = 0;
            announced = 0;
            popped    = 0;
            burst     = 1'b0;
        end
        if (flush) begin
            model_q.delete();
        end
        settle();
    endtask

    task automatic check_stat();
        logic [`FW_DATA_W-1:0] want;
        want      = '0;
        want[7]   = exp_avail;
        want[6]   = (model_q.size() == `FW_DEPTH);
        want[5]   = (model_q.size() == 0);
        want[4:0] = 5'(model_q.size());
        apb_xfer(1'b0, `FW_ADDR_STAT, '0);
        if (rdata !== want) begin
            $display("ERROR prdata (STATUS): got %h expected %h", rdata, want);
            errors++;
        end
        settle();
    endtask

    // Data access must sit in wait states; the bus is then released
    task automatic expect_stall(input logic wr);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: `FW_ADDR_DATA,
                     pwdata: 32'hdead_beef};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (apb_rsp.pready) begin
                $display("pready rose on a data access that should have stalled");
                errors++;
            end
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic check_flag(input logic want);
        @(negedge clk);
        if (avail !== want) begin
            $display("ERROR avail_o: got %h expected %h", avail, want);
            errors++;
        end
    endtask

    task automatic random_traffic(input int steps);
        repeat (steps) begin
            if (model_q.size() == 0 ||
                (model_q.size() < `FW_DEPTH && $urandom_range(1) == 1)) begin
                push_word($urandom());
            end else begin
                pop_word();
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s: %s, %0d errors", ntests + 1, name,
                 (errors == test_start) ? "ok" : "failed", errors - test_start);
        test_start = errors;
        ntests++;
    endtask

    initial begin
        logic [31:0] seed_ret;
        avail_cfg_t  c;
        clk        = 1'b0;
        rst_n      = 1'b0;
        apb_req    = '0;
        cfg        = '0;
        burst      = 1'b0;
        exp_avail  = 1'b0;
        chk_en     = 1'b0;
        pending    = 0;
        announced  = 0;
        popped     = 0;
        errors     = 0;
        test_start = 0;
        ntests     = 0;
        seed_ret   = $urandom(32'hfb25_33d5);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        settle();

        // Order, STATUS and unmapped offset
        repeat (`FW_DEPTH) begin
            push_word($urandom());
        end
        check_stat();
        repeat (`FW_DEPTH) begin
            pop_word();
            check_stat();
        end
        apb_xfer(1'b0, 4'hc, '0);
        if (!slverr) begin
            $display("Offset c completed without pslverr");
            errors++;
        end
        settle();
        end_test("order and status");

        // Full FIFO stalls writes, empty FIFO stalls reads
        repeat (`FW_DEPTH) begin
            push_word($urandom());
        end
        expect_stall(1'b1);
        pop_word();
        push_word($urandom());
        check_stat();
        repeat (`FW_DEPTH) begin
            pop_word();
        end
        expect_stall(1'b0);
        push_word($urandom());
        pop_word();
        end_test("back-pressure");

        c = '{enable: 1'b1, mode: MODE_NOT_EMPTY, thresh: 5'd0};
        write_ctrl(c, 1'b0);
        random_traffic(40);
        end_test("not-empty mode");

        c.mode   = MODE_THRESH;
        c.thresh = 5'($urandom_range(16, 1));
        write_ctrl(c, 1'b0);
        random_traffic(60);
        while (model_q.size() > 0) begin
            pop_word();
        end
        end_test("threshold mode");

        // Burst announce, drain, re-arm, then restart after disable
        c.mode = MODE_BURST;
        write_ctrl(c, 1'b0);
        repeat (3) begin
            push_word($urandom());
        end
        check_flag(1'b0);
        push_word($urandom());
        check_flag(1'b1);
        check_stat();
        repeat (2) begin
            push_word($urandom());
        end
        repeat (3) begin
            pop_word();
        end
        check_flag(1'b1);
        pop_word();
        check_flag(1'b0);
        repeat (2) begin
            push_word($urandom());
        end
        check_flag(1'b1);
        c.enable = 1'b0;
        write_ctrl(c, 1'b0);
        check_flag(1'b0);
        c.enable = 1'b1;
        write_ctrl(c, 1'b0);
        repeat (3) begin
            push_word($urandom());
        end
        check_flag(1'b0);
        push_word($urandom());
        check_flag(1'b1);
        end_test("burst mode");

        c = '0;
        write_ctrl(c, 1'b0);
        push_word($urandom());
        write_ctrl(c, 1'b1);
        check_stat();
        expect_stall(1'b0);
        end_test("clear");

        $display("Tests run: %0d, errors: %0d", ntests, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
